// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_isa_pkg.sv
  - logic/core_pkg.sv
  - logic/pipe_if.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/mem_stage.sv
  - logic/hazard_unit.sv
  - logic/rv_core.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/rv_core_chk.sv
      - bench/tb_rv_core.sv

// File: bench/rv_core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_chk #(
	parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
	input wire                              clk,
	input wire                              reset,
	input wire [rv_isa_pkg::xlen-1:0]       imem_addr,
	input wire [rv_isa_pkg::xlen-1:0]       dmem_addr,
	input wire [rv_isa_pkg::xlen-1:0]       dmem_wdata,
	input wire                              dmem_we,
	input wire                              dmem_re
);

	localparam int                          n_results   = 13;
	localparam logic [rv_isa_pkg::xlen-1:0] result_base = 32'h0000_0040;
	localparam logic [rv_isa_pkg::xlen-1:0] poison_addr = 32'h0000_00f0;
	localparam logic [rv_isa_pkg::xlen-1:0] done_addr   = 32'h0000_00fc;

	logic [rv_isa_pkg::xlen-1:0] expected [n_results];
	logic [rv_isa_pkg::xlen-1:0] offset;
	logic [rv_isa_pkg::xlen-1:0] want;
	logic                        in_results;
	logic [rv_isa_pkg::xlen-1:0] x1;
	logic [rv_isa_pkg::xlen-1:0] x3;
	logic [rv_isa_pkg::xlen-1:0] x5;
	logic [rv_isa_pkg::xlen-1:0] x8;
	int                          store_count;
	int                          fail_count = 0;

	// register values of the program, by the RV32 rules
	initial begin
		x1 = 32'd21;
		x3 = x1 + (x1 + 32'd100);
		x5 = (x3 - x1) << 3;
		x8 = ((x5 >> 2) & x3) | x1;
		expected[0]  = x3;
		expected[1]  = x3 - x1;
		expected[2]  = x5 >> 2;
		expected[3]  = (x5 >> 2) & x3;
		expected[4]  = x8;
		expected[5]  = x8 & 32'd240;
		expected[6]  = (x8 & 32'd240) << 5;
		expected[7]  = x5 >> 5;
		expected[8]  = x3 + 32'd7;         // reloaded from result 0
		expected[9]  = 32'd0 - 32'd5;
		expected[10] = x1;
		expected[11] = reset_pc + 32'd164; // jal sits at word 40
		expected[12] = reset_pc + 32'd184; // jalr sits at word 45
	end

	assign offset     = dmem_addr - result_base;
	assign in_results = offset < n_results * 4 && offset[1:0] == 2'b00;
	assign want       = in_results ? expected[offset[5:2]] : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			store_count <= 0;
		else if (dmem_we && dmem_addr != done_addr)
			store_count <= store_count + 1;
	end

	////////////////////////////////////////
	// assertions
	////////////////////////////////////////

	a_reset_state: assert property (@(posedge clk)
		reset |=> (imem_addr == reset_pc && !dmem_we && !dmem_re))
	else begin
		fail_count++;
		$error("ERR %0t: fetch address %h or data strobes not in reset state", $time,
			$sampled(imem_addr));
	end

	a_result_value: assert property (@(posedge clk) disable iff (reset)
		(dmem_we && in_results) |-> dmem_wdata == want)
	else begin
		fail_count++;
		$error("ERR %0t: store to %h wrote %h, expected %h", $time, $sampled(dmem_addr),
			$sampled(dmem_wdata), $sampled(want));
	end

	a_no_poison: assert property (@(posedge clk) disable iff (reset)
		dmem_we |-> dmem_addr != poison_addr)
	else begin
		fail_count++;
		$error("an annulled store reached the poison address at %0t", $time);
	end

	a_known_addr: assert property (@(posedge clk) disable iff (reset)
		(dmem_we && dmem_addr != poison_addr) |-> (in_results || dmem_addr == done_addr))
	else begin
		fail_count++;
		$error("store to unexpected address %h at %0t", $sampled(dmem_addr), $time);
	end

	a_store_count: assert property (@(posedge clk) disable iff (reset)
		(dmem_we && dmem_addr == done_addr) |-> store_count == n_results)
	else begin
		fail_count++;
		$error("ERR %0t: %0d stores before done, expected %0d", $time,
			$sampled(store_count), n_results);
	end

endmodule

bind rv_core rv_core_chk #(.reset_pc(reset_pc)) u_chk (
	.clk(clk), .reset(reset), .imem_addr(imem_addr),
	.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
	.dmem_we(dmem_we), .dmem_re(dmem_re)
);

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int half_period  = 2, // 4 ns clock
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0; // released on a rising edge
	end

endmodule

`default_nettype wire

// File: bench/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

	localparam logic [31:0] reset_pc       = 32'h0000_0100;
	localparam logic [31:0] done_addr      = 32'h0000_00fc;
	localparam int          imem_words     = 64;
	localparam int          dmem_words     = 64;
	localparam int          timeout_cycles = 400;
	localparam logic [6:0]  op_imm         = 7'b0010011;
	localparam logic [6:0]  op_load        = 7'b0000011;
	localparam logic [6:0]  op_jalr        = 7'b1100111;

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic        dmem_re;
	logic [31:0] dmem_rdata;
	logic [31:0] imem_offset;
	logic        imem_hit;
	logic [31:0] imem [imem_words];
	logic [31:0] dmem [dmem_words];
	logic        done_seen;
	int          timeouts;

	tb_clock u_clock (.clk(clk), .reset(reset));

	rv_core #(.reset_pc(reset_pc)) i_dut (
		.clk(clk), .reset(reset),
		.imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata)
	);

	////////////////////////////////////////
	// instruction encoders
	////////////////////////////////////////

	function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] itype_word(input logic [6:0] op, input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
	endfunction

	function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic load_program();
		for (int i = 0; i < imem_words; i++)
			imem[i] = store_word(12'h0f0, 1, 0); // poison store in every unused slot
		imem[0]  = itype_word(op_imm, 12'd21, 0, 3'b000, 1);    // addi x1, x0, 21
		imem[1]  = itype_word(op_imm, 12'd100, 1, 3'b000, 2);   // addi x2, x1, 100
		imem[2]  = rtype_word(7'h00, 2, 1, 3'b000, 3);          // add x3, x1, x2
		imem[3]  = rtype_word(7'h20, 1, 3, 3'b000, 4);          // sub x4, x3, x1
		imem[4]  = itype_word(op_imm, 12'd3, 4, 3'b001, 5);     // slli x5, x4, 3
		imem[5]  = itype_word(op_imm, 12'd2, 5, 3'b101, 6);     // srli x6, x5, 2
		imem[6]  = rtype_word(7'h00, 3, 6, 3'b111, 7);          // and x7, x6, x3
		imem[7]  = rtype_word(7'h00, 1, 7, 3'b110, 8);          // or x8, x7, x1
		imem[8]  = itype_word(op_imm, 12'd240, 8, 3'b111, 9);   // andi x9, x8, 240
		imem[9]  = itype_word(op_imm, 12'd5, 0, 3'b000, 11);    // addi x11, x0, 5
		imem[10] = rtype_word(7'h00, 11, 9, 3'b001, 10);        // sll x10, x9, x11
		imem[11] = rtype_word(7'h00, 11, 5, 3'b101, 12);        // srl x12, x5, x11
		imem[12] = store_word(12'h040, 3, 0);
		imem[13] = store_word(12'h044, 4, 0);
		imem[14] = store_word(12'h048, 6, 0);
		imem[15] = store_word(12'h04c, 7, 0);
		imem[16] = store_word(12'h050, 8, 0);
		imem[17] = store_word(12'h054, 9, 0);
		imem[18] = store_word(12'h058, 10, 0);
		imem[19] = store_word(12'h05c, 12, 0);
		imem[20] = itype_word(op_load, 12'h040, 0, 3'b010, 13); // lw x13, 0x40(x0)
		imem[21] = itype_word(op_imm, 12'd7, 13, 3'b000, 14);   // load-use on x13
		imem[22] = store_word(12'h060, 14, 0);
		imem[23] = itype_word(op_imm, -12'sd5, 0, 3'b000, 15);  // x15 = -5
		imem[24] = branch_word(13'd16, 1, 1, 3'b000);           // beq x1, x1 taken
		imem[28] = branch_word(13'd16, 1, 15, 3'b100);          // blt x15, x1 taken
		imem[32] = branch_word(13'd16, 15, 1, 3'b101);          // bge x1, x15 taken
		imem[36] = branch_word(13'd8, 15, 1, 3'b100);           // blt x1, x15 not taken
		imem[37] = store_word(12'h064, 15, 0);
		imem[38] = branch_word(13'd8, 1, 15, 3'b101);           // bge x15, x1 not taken
		imem[39] = store_word(12'h068, 1, 0);
		imem[40] = jal_word(21'd16, 16);                        // jal x16, +16
		imem[44] = store_word(12'h06c, 16, 0);
		imem[45] = itype_word(op_jalr, 12'd32, 16, 3'b000, 17); // jalr x17, 32(x16)
		imem[49] = store_word(12'h070, 17, 0);
		imem[50] = store_word(done_addr[11:0], 1, 0);
		imem[51] = jal_word(21'd0, 0);                          // park
	endtask

	////////////////////////////////////////
	// memory models
	////////////////////////////////////////

	assign imem_offset = imem_addr - reset_pc;
	assign imem_hit    = imem_offset < imem_words * 4 && imem_offset[1:0] == 2'b00;
	assign imem_rdata  = imem_hit ? imem[imem_offset[7:2]] : 32'h0000_0013;

	initial begin
		dmem_rdata = '0;
		for (int i = 0; i < dmem_words; i++)
			dmem[i] = 32'hd000_0000 | (i << 2); // tagged with its byte address
	end

	always @(posedge clk) begin
		if (dmem_we)
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		if (dmem_re)
			dmem_rdata <= dmem[dmem_addr[7:2]]; // one cycle latency
	end

	initial begin
		timeouts  = 0;
		done_seen = 1'b0;
		load_program();
		for (int cycle = 0; cycle < timeout_cycles && !done_seen; cycle++) begin
			@(negedge clk);
			done_seen = !reset && dmem_we && dmem_addr == done_addr;
		end
		if (!done_seen) begin
			timeouts++;
			$display("timeout: no store to the done address within %0d cycles", timeout_cycles);
		end
		@(negedge clk); // checker sees the done cycle first
		$display("assertion failures: %0d, timeouts: %0d", i_dut.u_chk.fail_count, timeouts);
		if (i_dut.u_chk.fail_count == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/pipe_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/hazard_unit.sv
logic/rv_core.sv
bench/tb_clock.sv
bench/rv_core_chk.sv
bench/tb_rv_core.sv

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_sll,
		alu_srl,
		alu_lt, // signed compare, result in bit 0
		alu_ge
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_none, // register file value
		fwd_wb,   // writeback data
		fwd_mem   // ex/mem alu result
	} fwd_sel_e;

	// coarse op group, refined by funct3/funct7 in execute
	typedef enum logic [1:0] {
		cls_mem,
		cls_branch,
		cls_reg,
		cls_imm
	} alu_class_e;

	typedef struct packed {
		logic       alu_src;    // operand b from immediate
		logic       mem_to_reg;
		logic       reg_write;
		logic       mem_read;
		logic       mem_write;
		logic       branch;
		logic       jump;       // jal or jalr
		logic       jalr;
		alu_class_e alu_class;
	} ctrl_t;

endpackage

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                stall,
	input  wire                                redirect,
	input  wire logic [rv_isa_pkg::xlen-1:0]   if_pc,
	input  wire rv_isa_pkg::instr_t            if_instr,
	mem_wb_if.reader                           wb,
	id_ex_if.driver                            id_ex
);

	logic [rv_isa_pkg::opcode_w-1:0]   opcode;
	logic [rv_isa_pkg::reg_addr_w-1:0] rd;
	logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
	logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
	logic [rv_isa_pkg::xlen-1:0]       imm;
	logic [rv_isa_pkg::xlen-1:0]       rs1_val;
	logic [rv_isa_pkg::xlen-1:0]       rs2_val;
	core_pkg::ctrl_t                   dec_ctrl;

	logic [rv_isa_pkg::xlen-1:0] regs [32];

	assign opcode = if_instr[6:0];
	assign rd     = if_instr[11:7];
	assign rs1    = if_instr[19:15];
	assign rs2    = if_instr[24:20];

	////////////////////////////////////////
	// control decode
	////////////////////////////////////////

	always_comb begin
		dec_ctrl = '0; // unknown opcodes become bubbles
		case (opcode)
			rv_isa_pkg::op_rtype: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.alu_class = core_pkg::cls_reg;
			end
			rv_isa_pkg::op_itype: begin
				dec_ctrl.alu_src   = 1'b1;
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.alu_class = core_pkg::cls_imm;
			end
			rv_isa_pkg::op_load: begin
				dec_ctrl.alu_src    = 1'b1;
				dec_ctrl.mem_to_reg = 1'b1;
				dec_ctrl.reg_write  = 1'b1;
				dec_ctrl.mem_read   = 1'b1;
			end
			rv_isa_pkg::op_store: begin
				dec_ctrl.alu_src   = 1'b1;
				dec_ctrl.mem_write = 1'b1;
			end
			rv_isa_pkg::op_branch: begin
				dec_ctrl.branch    = 1'b1;
				dec_ctrl.alu_class = core_pkg::cls_branch;
			end
			rv_isa_pkg::op_jal: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.jump      = 1'b1;
			end
			rv_isa_pkg::op_jalr: begin
				dec_ctrl.alu_src   = 1'b1; // target is rs1 + imm
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.jump      = 1'b1;
				dec_ctrl.jalr      = 1'b1;
			end
			default: ;
		endcase
	end

	// b and j immediates leave out bit 0, execute shifts them back
	always_comb begin
		case (opcode)
			rv_isa_pkg::op_itype,
			rv_isa_pkg::op_load,
			rv_isa_pkg::op_jalr:   imm = {{20{if_instr[31]}}, if_instr[31:20]};
			rv_isa_pkg::op_store:  imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
			rv_isa_pkg::op_branch: imm = {{20{if_instr[31]}}, if_instr[31], if_instr[7],
				if_instr[30:25], if_instr[11:8]};
			rv_isa_pkg::op_jal:    imm = {{12{if_instr[31]}}, if_instr[31], if_instr[19:12],
				if_instr[20], if_instr[30:21]};
			default:               imm = '0;
		endcase
	end

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wb.reg_write && wb.rd != '0)
			regs[wb.rd] <= wb.wb_data;
	end

	assign rs1_val = (rs1 == '0) ? '0 :
		(wb.reg_write && wb.rd == rs1) ? wb.wb_data : regs[rs1]; // write-through
	assign rs2_val = (rs2 == '0) ? '0 :
		(wb.reg_write && wb.rd == rs2) ? wb.wb_data : regs[rs2];

	// id/ex register
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			id_ex.ctrl <= '0;
		else if (stall || redirect)
			id_ex.ctrl <= '0; // bubble for load-use or annulled slot
		else
			id_ex.ctrl <= dec_ctrl;
	end

	always_ff @(posedge clk) begin
		id_ex.pc       <= if_pc;
		id_ex.rs1_data <= rs1_val;
		id_ex.rs2_data <= rs2_val;
		id_ex.imm      <= imm;
		id_ex.rd       <= rd;
		id_ex.rs1      <= rs1;
		id_ex.rs2      <= rs2;
		id_ex.funct3   <= if_instr[14:12];
		id_ex.funct7   <= if_instr[31:25];
	end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                redirect,
	input  wire core_pkg::fwd_sel_e            fwd_a,
	input  wire core_pkg::fwd_sel_e            fwd_b,
	id_ex_if.reader                            id_ex,
	ex_mem_if.driver                           ex_mem,
	mem_wb_if.reader                           wb
);

	localparam int shamt_w = $clog2(rv_isa_pkg::xlen);

	logic [rv_isa_pkg::xlen-1:0] op_a;
	logic [rv_isa_pkg::xlen-1:0] rs2_fwd;
	logic [rv_isa_pkg::xlen-1:0] op_b;
	logic [rv_isa_pkg::xlen-1:0] alu_y;
	logic                        cond;
	core_pkg::alu_op_e           alu_op;

	function automatic logic [rv_isa_pkg::xlen-1:0] fwd_mux(
		input core_pkg::fwd_sel_e          sel,
		input logic [rv_isa_pkg::xlen-1:0] reg_val,
		input logic [rv_isa_pkg::xlen-1:0] mem_val,
		input logic [rv_isa_pkg::xlen-1:0] wb_val
	);
		case (sel)
			core_pkg::fwd_mem: return mem_val;
			core_pkg::fwd_wb:  return wb_val;
			default:           return reg_val;
		endcase
	endfunction

	assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb.wb_data);
	assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb.wb_data);
	assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;

	////////////////////////////////////////
	// alu op select and alu
	////////////////////////////////////////

	always_comb begin
		alu_op = core_pkg::alu_add; // loads, stores, jalr
		case (id_ex.ctrl.alu_class)
			core_pkg::cls_branch:
				case (id_ex.funct3)
					rv_isa_pkg::f3_blt: alu_op = core_pkg::alu_lt;
					rv_isa_pkg::f3_bge: alu_op = core_pkg::alu_ge;
					default:            alu_op = core_pkg::alu_sub; // beq
				endcase
			core_pkg::cls_reg, core_pkg::cls_imm:
				case (id_ex.funct3)
					rv_isa_pkg::f3_add:
						if (id_ex.ctrl.alu_class == core_pkg::cls_reg &&
							id_ex.funct7 == rv_isa_pkg::f7_sub)
							alu_op = core_pkg::alu_sub;
					rv_isa_pkg::f3_sll: alu_op = core_pkg::alu_sll;
					rv_isa_pkg::f3_srl: alu_op = core_pkg::alu_srl;
					rv_isa_pkg::f3_or:  alu_op = core_pkg::alu_or;
					rv_isa_pkg::f3_and: alu_op = core_pkg::alu_and;
					default: ;
				endcase
			default: ;
		endcase
	end

	always_comb begin
		alu_y = '0;
		case (alu_op)
			core_pkg::alu_add: alu_y = op_a + op_b;
			core_pkg::alu_sub: alu_y = op_a - op_b;
			core_pkg::alu_and: alu_y = op_a & op_b;
			core_pkg::alu_or:  alu_y = op_a | op_b;
			core_pkg::alu_sll: alu_y = op_a << op_b[shamt_w-1:0];
			core_pkg::alu_srl: alu_y = op_a >> op_b[shamt_w-1:0];
			core_pkg::alu_lt:  alu_y[0] = $signed(op_a) < $signed(op_b);
			core_pkg::alu_ge:  alu_y[0] = $signed(op_a) >= $signed(op_b);
			default: ;
		endcase
	end

	always_comb begin
		case (id_ex.funct3)
			rv_isa_pkg::f3_beq: cond = (alu_y == '0);
			rv_isa_pkg::f3_blt,
			rv_isa_pkg::f3_bge: cond = alu_y[0];
			default:            cond = 1'b0;
		endcase
	end

	// ex/mem register
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ex_mem.ctrl <= '0;
		else if (redirect)
			ex_mem.ctrl <= '0; // oldest annulled slot
		else
			ex_mem.ctrl <= id_ex.ctrl;
	end

	always_ff @(posedge clk) begin
		ex_mem.pc            <= id_ex.pc;
		ex_mem.alu_result    <= alu_y;
		ex_mem.branch_target <= id_ex.pc + (id_ex.imm << 1);
		ex_mem.store_data    <= rs2_fwd;
		ex_mem.rd            <= id_ex.rd;
		ex_mem.zero          <= cond;
	end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
	parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
	input  wire                                clk,
	input  wire                                reset,
	input  wire logic                          stall,
	input  wire logic                          redirect,
	input  wire logic [rv_isa_pkg::xlen-1:0]   redirect_pc,
	output logic [rv_isa_pkg::xlen-1:0]        imem_addr,
	input  wire rv_isa_pkg::instr_t            imem_rdata,
	output logic [rv_isa_pkg::xlen-1:0]        if_pc,
	output rv_isa_pkg::instr_t                 if_instr
);

	localparam logic [rv_isa_pkg::xlen-1:0] pc_step = 4;

	logic [rv_isa_pkg::xlen-1:0] pc;

	assign imem_addr = pc; // imem answers in the same cycle

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc       <= reset_pc;
			if_instr <= rv_isa_pkg::nop_instr;
		end else if (redirect) begin
			pc       <= redirect_pc;
			if_instr <= rv_isa_pkg::nop_instr; // kill the word fetched this cycle
		end else if (!stall) begin
			pc       <= pc + pc_step;
			if_instr <= imem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			if_pc <= pc;
	end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input  wire rv_isa_pkg::instr_t            if_instr,
	id_ex_if.reader                            id_ex,
	ex_mem_if.reader                           ex_mem,
	mem_wb_if.reader                           wb,
	output logic                               stall,
	output core_pkg::fwd_sel_e                 fwd_a,
	output core_pkg::fwd_sel_e                 fwd_b
);

	logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
	logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
	logic                              use_rs1;
	logic                              use_rs2;

	function automatic core_pkg::fwd_sel_e fwd_pick(
		input logic [rv_isa_pkg::reg_addr_w-1:0] src
	);
		if (ex_mem.ctrl.reg_write && ex_mem.rd != '0 && ex_mem.rd == src)
			return core_pkg::fwd_mem; // youngest result wins
		else if (wb.reg_write && wb.rd != '0 && wb.rd == src)
			return core_pkg::fwd_wb;
		else
			return core_pkg::fwd_none;
	endfunction

	assign rs1 = if_instr[19:15];
	assign rs2 = if_instr[24:20];

	// only real source fields count, immediates can alias rs2
	always_comb begin
		use_rs1 = 1'b1;
		use_rs2 = 1'b0;
		case (if_instr[6:0])
			rv_isa_pkg::op_rtype,
			rv_isa_pkg::op_store,
			rv_isa_pkg::op_branch: use_rs2 = 1'b1;
			rv_isa_pkg::op_jal:    use_rs1 = 1'b0;
			default: ;
		endcase
	end

	assign stall = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		((use_rs1 && rs1 == id_ex.rd) || (use_rs2 && rs2 == id_ex.rd));

	// also follows the ex/mem and mem/wb fields read inside fwd_pick
	always_comb begin
		fwd_a = fwd_pick(id_ex.rs1);
		fwd_b = fwd_pick(id_ex.rs2);
	end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
	input  wire                                clk,
	input  wire                                reset,
	ex_mem_if.reader                           ex_mem,
	output logic [rv_isa_pkg::xlen-1:0]        dmem_addr,
	output logic [rv_isa_pkg::xlen-1:0]        dmem_wdata,
	output logic                               dmem_we,
	output logic                               dmem_re,
	input  wire logic [rv_isa_pkg::xlen-1:0]   dmem_rdata,
	output logic                               redirect,
	output logic [rv_isa_pkg::xlen-1:0]        redirect_pc,
	mem_wb_if.driver                           wb
);

	localparam logic [rv_isa_pkg::xlen-1:0] link_step = 4;

	logic                        wb_mem_to_reg;
	logic                        wb_link;
	logic [rv_isa_pkg::xlen-1:0] wb_alu;
	logic [rv_isa_pkg::xlen-1:0] wb_pc;

	// branch resolution
	assign redirect    = ex_mem.ctrl.jump || (ex_mem.ctrl.branch && ex_mem.zero);
	assign redirect_pc = ex_mem.ctrl.jalr ? {ex_mem.alu_result[rv_isa_pkg::xlen-1:1], 1'b0} :
		ex_mem.branch_target;

	assign dmem_addr  = ex_mem.alu_result;
	assign dmem_wdata = ex_mem.store_data;
	assign dmem_we    = ex_mem.ctrl.mem_write;
	assign dmem_re    = ex_mem.ctrl.mem_read; // data comes back next cycle

	////////////////////////////////////////
	// mem/wb register and writeback select
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb.reg_write  <= 1'b0;
			wb_mem_to_reg <= 1'b0;
			wb_link       <= 1'b0;
		end else begin
			wb.reg_write  <= ex_mem.ctrl.reg_write;
			wb_mem_to_reg <= ex_mem.ctrl.mem_to_reg;
			wb_link       <= ex_mem.ctrl.jump;
		end
	end

	always_ff @(posedge clk) begin
		wb.rd  <= ex_mem.rd;
		wb_alu <= ex_mem.alu_result;
		wb_pc  <= ex_mem.pc;
	end

	assign wb.wb_data = wb_mem_to_reg ? dmem_rdata :
		wb_link ? wb_pc + link_step : wb_alu;

endmodule

`default_nettype wire

// File: logic/pipe_if.sv
`timescale 1ns/10ps
`default_nettype none

interface id_ex_if;
	core_pkg::ctrl_t                        ctrl;
	logic [rv_isa_pkg::xlen-1:0]            pc;
	logic [rv_isa_pkg::xlen-1:0]            rs1_data;
	logic [rv_isa_pkg::xlen-1:0]            rs2_data;
	logic [rv_isa_pkg::xlen-1:0]            imm;
	logic [rv_isa_pkg::reg_addr_w-1:0]      rd;
	logic [rv_isa_pkg::reg_addr_w-1:0]      rs1;
	logic [rv_isa_pkg::reg_addr_w-1:0]      rs2;
	logic [rv_isa_pkg::funct3_w-1:0]        funct3;
	logic [rv_isa_pkg::funct7_w-1:0]        funct7;

	modport driver (output ctrl, pc, rs1_data, rs2_data, imm, rd, rs1, rs2, funct3, funct7);
	modport reader (input ctrl, pc, rs1_data, rs2_data, imm, rd, rs1, rs2, funct3, funct7);
endinterface

interface ex_mem_if;
	core_pkg::ctrl_t                        ctrl;
	logic [rv_isa_pkg::xlen-1:0]            pc;
	logic [rv_isa_pkg::xlen-1:0]            alu_result;
	logic [rv_isa_pkg::xlen-1:0]            branch_target;
	logic [rv_isa_pkg::xlen-1:0]            store_data;
	logic [rv_isa_pkg::reg_addr_w-1:0]      rd;
	logic                                   zero; // branch condition holds

	modport driver (output ctrl, pc, alu_result, branch_target, store_data, rd, zero);
	modport reader (input ctrl, pc, alu_result, branch_target, store_data, rd, zero);
endinterface

interface mem_wb_if;
	logic                                   reg_write;
	logic [rv_isa_pkg::reg_addr_w-1:0]      rd;
	logic [rv_isa_pkg::xlen-1:0]            wb_data;

	modport driver (output reg_write, rd, wb_data);
	modport reader (input reg_write, rd, wb_data);
endinterface

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
	parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
	input  wire                                clk,
	input  wire                                reset,
	output logic [rv_isa_pkg::xlen-1:0]        imem_addr,
	input  wire rv_isa_pkg::instr_t            imem_rdata,
	output logic [rv_isa_pkg::xlen-1:0]        dmem_addr,
	output logic [rv_isa_pkg::xlen-1:0]        dmem_wdata,
	output logic                               dmem_we,
	output logic                               dmem_re,
	input  wire logic [rv_isa_pkg::xlen-1:0]   dmem_rdata
);

	logic                        redirect;
	logic [rv_isa_pkg::xlen-1:0] redirect_pc;
	logic                        stall;
	core_pkg::fwd_sel_e          fwd_a;
	core_pkg::fwd_sel_e          fwd_b;
	logic [rv_isa_pkg::xlen-1:0] if_pc;
	rv_isa_pkg::instr_t          if_instr;

	id_ex_if  id_ex ();
	ex_mem_if ex_mem ();
	mem_wb_if mem_wb ();

	////////////////////////////////////////
	// pipeline stages
	////////////////////////////////////////

	fetch_stage #(.reset_pc(reset_pc)) u_fetch (
		.clk(clk), .reset(reset),
		.stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.if_pc(if_pc), .if_instr(if_instr)
	);

	decode_stage u_decode (
		.clk(clk), .reset(reset),
		.stall(stall), .redirect(redirect),
		.if_pc(if_pc), .if_instr(if_instr),
		.wb(mem_wb.reader), .id_ex(id_ex.driver)
	);

	execute_stage u_execute (
		.clk(clk), .reset(reset), .redirect(redirect),
		.fwd_a(fwd_a), .fwd_b(fwd_b),
		.id_ex(id_ex.reader), .ex_mem(ex_mem.driver), .wb(mem_wb.reader)
	);

	mem_stage u_mem (
		.clk(clk), .reset(reset), .ex_mem(ex_mem.reader),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata),
		.redirect(redirect), .redirect_pc(redirect_pc), .wb(mem_wb.driver)
	);

	hazard_unit u_hazard (
		.if_instr(if_instr),
		.id_ex(id_ex.reader), .ex_mem(ex_mem.reader), .wb(mem_wb.reader),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	localparam int xlen       = 32; // data and address width
	localparam int reg_addr_w = 5;  // register index
	localparam int opcode_w   = 7;
	localparam int funct3_w   = 3;
	localparam int funct7_w   = 7;

	typedef logic [31:0] instr_t;

	////////////////////////////////////////
	// major opcodes
	////////////////////////////////////////

	localparam logic [opcode_w-1:0] op_rtype  = 7'b0110011; // add sub and or sll srl
	localparam logic [opcode_w-1:0] op_itype  = 7'b0010011; // addi andi slli srli
	localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
	localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
	localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
	localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
	localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;

	////////////////////////////////////////
	// funct3 and funct7
	////////////////////////////////////////

	localparam logic [funct3_w-1:0] f3_add = 3'b000; // also sub
	localparam logic [funct3_w-1:0] f3_sll = 3'b001;
	localparam logic [funct3_w-1:0] f3_srl = 3'b101;
	localparam logic [funct3_w-1:0] f3_or  = 3'b110;
	localparam logic [funct3_w-1:0] f3_and = 3'b111;
	localparam logic [funct3_w-1:0] f3_beq = 3'b000;
	localparam logic [funct3_w-1:0] f3_blt = 3'b100; // signed
	localparam logic [funct3_w-1:0] f3_bge = 3'b101; // signed

	localparam logic [funct7_w-1:0] f7_sub = 7'b0100000;

	localparam instr_t nop_instr = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire
